// ==== logic/pcie_app_pkg.sv ====
// --------------------
// Stream lengths and source addresses are assumed to be multiples of 8 bytes
// --------------------

package pcie_app_pkg;

  // Sizes
  localparam int NUM_STRM     = 4;
  localparam int ADDR_W       = 32;
  localparam int DATA_W       = 64;
  localparam int LEN_W        = 12;
  localparam int REG_ADDR_W   = 10;
  localparam int MAX_RD_BYTES = 128;
  localparam logic [7:0] TAG_BASE = 8'd4;

  // Stream buffer holds one full read request
  localparam int BUF_DEPTH  = MAX_RD_BYTES / (DATA_W / 8);
  localparam int BUF_AW     = $clog2(BUF_DEPTH);
  localparam int WCNT_W     = $clog2(BUF_DEPTH + 1);
  localparam int STRM_IDX_W = $clog2(NUM_STRM);

  // Register word addresses, per-stream pairs start at REG_SRC_BASE
  typedef enum logic [REG_ADDR_W-1:0] {
    REG_CTRL     = 10'd0,
    REG_STATUS   = 10'd1,
    REG_SRC_BASE = 10'd8,
    REG_LEN_BASE = 10'd9
  } reg_addr_e;

  typedef enum logic [1:0] {
    STRM_IDLE,
    STRM_REQ,
    STRM_DATA,
    STRM_DRAIN
  } strm_state_e;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [7:0]        tag;
  } rd_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] src_addr;
    logic [31:0]       byte_len;
  } strm_cfg_t;

endpackage

// ==== logic/pcie_reg_file.sv ====
// --------------------
// Source and length must not change while the stream's enable bit is set
// --------------------

`timescale 1ns/100ps

module pcie_reg_file (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  logic                                   reg_wr_i,
  input  logic                                   reg_rd_i,
  input  logic [pcie_app_pkg::REG_ADDR_W-1:0]    reg_addr_i,
  input  logic [31:0]                            reg_wdata_i,
  output logic [31:0]                            reg_rdata_o,
  output logic                                   reg_rd_ack_o,
  output logic [pcie_app_pkg::NUM_STRM-1:0]      strm_en_o,
  output pcie_app_pkg::strm_cfg_t [pcie_app_pkg::NUM_STRM-1:0] strm_cfg_o,
  input  logic [pcie_app_pkg::NUM_STRM-1:0]      strm_done_i
);

  import pcie_app_pkg::*;

  logic [NUM_STRM-1:0]             ctrl_q;
  logic [NUM_STRM-1:0]             ctrl_nxt;
  logic [NUM_STRM-1:0]             status_q;
  logic [NUM_STRM-1:0]             status_nxt;
  strm_cfg_t [NUM_STRM-1:0]        cfg_q;
  logic [31:0]                     rd_mux;
  logic [31:0]                     rdata_q;
  logic                            rd_ack_q;

  // --------------------
  // Control and status
  // --------------------
  always_comb
  begin
    ctrl_nxt   = ctrl_q;
    status_nxt = status_q;
    if (reg_wr_i && reg_addr_i == REG_CTRL)
      ctrl_nxt = reg_wdata_i[NUM_STRM-1:0];
    // Write 1 to clear
    if (reg_wr_i && reg_addr_i == REG_STATUS)
      status_nxt = status_q & ~reg_wdata_i[NUM_STRM-1:0];
    // Done pulse wins over both writes
    ctrl_nxt   = ctrl_nxt & ~strm_done_i;
    status_nxt = status_nxt | strm_done_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      ctrl_q   <= '0;
      status_q <= '0;
    end
    else
    begin
      ctrl_q   <= ctrl_nxt;
      status_q <= status_nxt;
    end
  end

  // --------------------
  // Per-stream source and length
  // --------------------
  always_ff @(posedge clk_i)
  begin
    if (reg_wr_i)
    begin
      for (int n = 0; n < NUM_STRM; n++)
      begin
        if (reg_addr_i == REG_ADDR_W'(REG_SRC_BASE + 2 * n))
          cfg_q[n].src_addr <= reg_wdata_i;
        if (reg_addr_i == REG_ADDR_W'(REG_LEN_BASE + 2 * n))
          cfg_q[n].byte_len <= reg_wdata_i;
      end
    end
  end

  // --------------------
  // Read path
  // --------------------
  always_comb
  begin
    case (reg_addr_i)
      REG_CTRL:   rd_mux = 32'(ctrl_q);
      REG_STATUS: rd_mux = 32'(status_q);
      default:    rd_mux = '0;
    endcase
    for (int n = 0; n < NUM_STRM; n++)
    begin
      if (reg_addr_i == REG_ADDR_W'(REG_SRC_BASE + 2 * n))
        rd_mux = cfg_q[n].src_addr;
      if (reg_addr_i == REG_ADDR_W'(REG_LEN_BASE + 2 * n))
        rd_mux = cfg_q[n].byte_len;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reg_rd_i)
      rdata_q <= rd_mux;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      rd_ack_q <= 1'b0;
    else
      rd_ack_q <= reg_rd_i;
  end

  assign reg_rdata_o  = rdata_q;
  assign reg_rd_ack_o = rd_ack_q;
  assign strm_en_o    = ctrl_q;
  assign strm_cfg_o   = cfg_q;

endmodule

// ==== logic/user_pcie_stream_gen.sv ====
// --------------------
// One request in flight, completions for it must arrive in address order
// --------------------

`timescale 1ns/100ps

module user_pcie_stream_gen #(
  parameter int STRM_ID = 0
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             en_i,
  input  pcie_app_pkg::strm_cfg_t          cfg_i,
  output logic                             done_o,
  output pcie_app_pkg::rd_req_t            rd_req_o,
  output logic                             rd_req_valid_o,
  input  logic                             rd_req_ack_i,
  input  logic                             cpl_valid_i,
  input  logic [7:0]                       cpl_tag_i,
  input  logic [pcie_app_pkg::DATA_W-1:0]  cpl_data_i,
  output logic                             strm_valid_o,
  input  logic                             strm_ack_i,
  output logic [pcie_app_pkg::DATA_W-1:0]  strm_data_o
);

  import pcie_app_pkg::*;

  strm_state_e          state_q;
  logic [31:0]          issued_q;
  logic [31:0]          remain;
  logic [LEN_W-1:0]     req_len;
  logic [WCNT_W-1:0]    words_left_q;
  logic [7:0]           strm_tag;
  logic                 xfer_end;
  logic                 push;
  logic                 pop;
  logic [DATA_W-1:0]    buf_mem [BUF_DEPTH];
  logic [BUF_AW-1:0]    wr_ptr_q;
  logic [BUF_AW-1:0]    rd_ptr_q;
  logic [WCNT_W-1:0]    fifo_cnt_q;

  assign strm_tag = TAG_BASE + 8'(STRM_ID);
  assign remain   = cfg_i.byte_len - issued_q;
  assign req_len  = (remain > 32'(MAX_RD_BYTES)) ? LEN_W'(MAX_RD_BYTES) : remain[LEN_W-1:0];
  assign xfer_end = (issued_q == cfg_i.byte_len);

  assign rd_req_valid_o = (state_q == STRM_REQ);
  assign rd_req_o.addr  = cfg_i.src_addr + issued_q;
  assign rd_req_o.len   = req_len;
  assign rd_req_o.tag   = strm_tag;

  // Ends in the same edge that returns to idle
  assign done_o = (state_q == STRM_DRAIN) && (fifo_cnt_q == '0) && xfer_end;

  // --------------------
  // Request sequencing
  // --------------------
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q      <= STRM_IDLE;
      issued_q     <= '0;
      words_left_q <= '0;
    end
    else
    begin
      case (state_q)
        STRM_IDLE:
          if (en_i)
          begin
            issued_q <= '0;
            state_q  <= STRM_DRAIN;
          end
        STRM_REQ:
          if (rd_req_ack_i)
          begin
            issued_q     <= issued_q + 32'(req_len);
            words_left_q <= WCNT_W'(req_len >> 3);
            state_q      <= STRM_DATA;
          end
        STRM_DATA:
          if (push)
          begin
            words_left_q <= words_left_q - 1'b1;
            if (words_left_q == WCNT_W'(1))
              state_q <= STRM_DRAIN;
          end
        STRM_DRAIN:
          // Next request only once the buffer is empty
          if (fifo_cnt_q == '0)
            state_q <= xfer_end ? STRM_IDLE : STRM_REQ;
        default:
          state_q <= STRM_IDLE;
      endcase
    end
  end

  // --------------------
  // Stream buffer
  // --------------------
  assign push = (state_q == STRM_DATA) && cpl_valid_i && (cpl_tag_i == strm_tag);
  assign pop  = strm_valid_o && strm_ack_i;

  always_ff @(posedge clk_i)
  begin
    if (push)
      buf_mem[wr_ptr_q] <= cpl_data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      fifo_cnt_q <= fifo_cnt_q + WCNT_W'(push) - WCNT_W'(pop);
    end
  end

  assign strm_valid_o = (fifo_cnt_q != '0);
  assign strm_data_o  = buf_mem[rd_ptr_q];

endmodule

// ==== logic/user_dma_req_arbiter.sv ====
// --------------------
// Requesters hold their level until acked, one grant is open at a time
// --------------------

`timescale 1ns/100ps

module user_dma_req_arbiter (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic [pcie_app_pkg::NUM_STRM-1:0]     slv_req_i,
  input  pcie_app_pkg::rd_req_t [pcie_app_pkg::NUM_STRM-1:0] slv_req_data_i,
  output logic [pcie_app_pkg::NUM_STRM-1:0]     slv_ack_o,
  output pcie_app_pkg::rd_req_t                 rd_req_o,
  output logic                                  rd_req_valid_o,
  input  logic                                  rd_req_ack_i
);

  import pcie_app_pkg::*;

  logic [STRM_IDX_W-1:0] last_q;
  logic [STRM_IDX_W-1:0] gnt_q;
  logic [STRM_IDX_W-1:0] pick;
  logic                  pick_vld;
  logic                  busy_q;
  rd_req_t               req_q;

  // First requester after the last grant
  always_comb
  begin
    pick     = last_q;
    pick_vld = 1'b0;
    for (int i = 1; i <= NUM_STRM; i++)
    begin
      if (!pick_vld && slv_req_i[(int'(last_q) + i) % NUM_STRM])
      begin
        pick     = STRM_IDX_W'((int'(last_q) + i) % NUM_STRM);
        pick_vld = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      busy_q <= 1'b0;
      gnt_q  <= '0;
      last_q <= STRM_IDX_W'(NUM_STRM - 1);
    end
    else if (!busy_q)
    begin
      if (pick_vld)
      begin
        busy_q <= 1'b1;
        gnt_q  <= pick;
      end
    end
    else if (rd_req_ack_i)
    begin
      busy_q <= 1'b0;
      last_q <= gnt_q;
    end
  end

  // Request payload captured at grant
  always_ff @(posedge clk_i)
  begin
    if (!busy_q && pick_vld)
      req_q <= slv_req_data_i[pick];
  end

  always_comb
  begin
    slv_ack_o = '0;
    if (busy_q && rd_req_ack_i)
      slv_ack_o[gnt_q] = 1'b1;
  end

  assign rd_req_o       = req_q;
  assign rd_req_valid_o = busy_q;

endmodule

// ==== logic/pcie_app.sv ====
// --------------------
// System-to-user read path only, no TLP layer
// --------------------

`timescale 1ns/100ps

module pcie_app (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  // Host register port
  input  logic                                  reg_wr_i,
  input  logic                                  reg_rd_i,
  input  logic [pcie_app_pkg::REG_ADDR_W-1:0]   reg_addr_i,
  input  logic [31:0]                           reg_wdata_i,
  output logic [31:0]                           reg_rdata_o,
  output logic                                  reg_rd_ack_o,
  // Read requests out
  output pcie_app_pkg::rd_req_t                 rd_req_o,
  output logic                                  rd_req_valid_o,
  input  logic                                  rd_req_ack_i,
  // Completions in
  input  logic                                  cpl_valid_i,
  input  logic [7:0]                            cpl_tag_i,
  input  logic [pcie_app_pkg::DATA_W-1:0]       cpl_data_i,
  // User streams
  output logic [pcie_app_pkg::NUM_STRM-1:0]     strm_valid_o,
  input  logic [pcie_app_pkg::NUM_STRM-1:0]     strm_ack_i,
  output logic [pcie_app_pkg::NUM_STRM-1:0][pcie_app_pkg::DATA_W-1:0] strm_data_o
);

  import pcie_app_pkg::*;

  logic [NUM_STRM-1:0]      strm_en;
  strm_cfg_t [NUM_STRM-1:0] strm_cfg;
  logic [NUM_STRM-1:0]      strm_done;
  logic [NUM_STRM-1:0]      gen_req;
  rd_req_t [NUM_STRM-1:0]   gen_req_data;
  logic [NUM_STRM-1:0]      gen_ack;

  pcie_reg_file reg_file_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .reg_wr_i     (reg_wr_i),
    .reg_rd_i     (reg_rd_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_o  (reg_rdata_o),
    .reg_rd_ack_o (reg_rd_ack_o),
    .strm_en_o    (strm_en),
    .strm_cfg_o   (strm_cfg),
    .strm_done_i  (strm_done)
  );

  for (genvar n = 0; n < NUM_STRM; n++)
  begin : gen_strm
    user_pcie_stream_gen #(
      .STRM_ID (n)
    ) psg_i (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .en_i           (strm_en[n]),
      .cfg_i          (strm_cfg[n]),
      .done_o         (strm_done[n]),
      .rd_req_o       (gen_req_data[n]),
      .rd_req_valid_o (gen_req[n]),
      .rd_req_ack_i   (gen_ack[n]),
      .cpl_valid_i    (cpl_valid_i),
      .cpl_tag_i      (cpl_tag_i),
      .cpl_data_i     (cpl_data_i),
      .strm_valid_o   (strm_valid_o[n]),
      .strm_ack_i     (strm_ack_i[n]),
      .strm_data_o    (strm_data_o[n])
    );
  end

  user_dma_req_arbiter dra_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .slv_req_i      (gen_req),
    .slv_req_data_i (gen_req_data),
    .slv_ack_o      (gen_ack),
    .rd_req_o       (rd_req_o),
    .rd_req_valid_o (rd_req_valid_o),
    .rd_req_ack_i   (rd_req_ack_i)
  );

endmodule

// ==== verification/pcie_app_tb.sv ====
// --------------------
// Completer serves one request at a time, so words of different tags never interleave
// --------------------

`timescale 1ns/100ps

module pcie_app_tb;

  import pcie_app_pkg::*;

  // Under 2000 cycles of traffic in all tests, wide margin for register polling
  localparam int TIMEOUT_CYC = 20000;

  logic                            clk = 1'b0;
  logic                            rst;
  logic                            reg_wr;
  logic                            reg_rd;
  logic [REG_ADDR_W-1:0]           reg_addr;
  logic [31:0]                     reg_wdata;
  logic [31:0]                     reg_rdata;
  logic                            reg_rd_ack;
  rd_req_t                         rd_req;
  logic                            rd_req_valid;
  logic                            rd_req_ack;
  logic                            cpl_valid;
  logic [7:0]                      cpl_tag;
  logic [DATA_W-1:0]               cpl_data;
  logic [NUM_STRM-1:0]             strm_valid;
  logic [NUM_STRM-1:0]             strm_ack;
  logic [NUM_STRM-1:0][DATA_W-1:0] strm_data;

  // Scoreboard and request log
  logic [31:0]         exp_addr [NUM_STRM];
  int                  exp_words [NUM_STRM];
  int                  rx_cnt [NUM_STRM];
  logic [NUM_STRM-1:0] rand_ack;
  rd_req_t             req_log [$];
  int                  cycle_cnt = 0;

  pcie_app pcie_app_i (
    .clk_i          (clk),
    .rst_i          (rst),
    .reg_wr_i       (reg_wr),
    .reg_rd_i       (reg_rd),
    .reg_addr_i     (reg_addr),
    .reg_wdata_i    (reg_wdata),
    .reg_rdata_o    (reg_rdata),
    .reg_rd_ack_o   (reg_rd_ack),
    .rd_req_o       (rd_req),
    .rd_req_valid_o (rd_req_valid),
    .rd_req_ack_i   (rd_req_ack),
    .cpl_valid_i    (cpl_valid),
    .cpl_tag_i      (cpl_tag),
    .cpl_data_i     (cpl_data),
    .strm_valid_o   (strm_valid),
    .strm_ack_i     (strm_ack),
    .strm_data_o    (strm_data)
  );

  always #5 clk = ~clk;

  // --------------------
  // Checking
  // --------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped at %0t ns", $time);
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp));
  endtask

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYC)
      fail_run("Timeout: the tests did not finish within the cycle limit");
  end

  // Host memory word at byte address a
  function automatic logic [63:0] mem_word(input logic [31:0] a);
    return {a, ~a};
  endfunction

  // --------------------
  // Stream side
  // --------------------
  always @(posedge clk)
  begin
    #1;
    for (int n = 0; n < NUM_STRM; n++)
      strm_ack[n] = rand_ack[n] ? 1'($urandom_range(1)) : 1'b1;
  end

  always @(negedge clk)
  begin
    for (int n = 0; n < NUM_STRM; n++)
    begin
      if (!rst && strm_valid[n] && strm_ack[n])
      begin
        if (rx_cnt[n] >= exp_words[n])
          fail_run($sformatf("Stream %0d delivered a word beyond its transfer", n));
        check_val($sformatf("strm_data_o[%0d]", n), strm_data[n], mem_word(exp_addr[n]));
        exp_addr[n] += 32'd8;
        rx_cnt[n]++;
      end
    end
  end

  // --------------------
  // Completer model
  // --------------------
  initial
  begin : completer
    rd_req_t req;
    forever
    begin
      @(negedge clk);
      if (!rst && rd_req_valid)
      begin
        req = rd_req;
        req_log.push_back(req);
        repeat ($urandom_range(3)) @(posedge clk);
        @(posedge clk);
        #1;
        rd_req_ack = 1'b1;
        @(posedge clk);
        #1;
        rd_req_ack = 1'b0;
        for (int i = 0; i < int'(req.len) / 8; i++)
        begin
          cpl_valid = 1'b1;
          cpl_tag   = req.tag;
          cpl_data  = mem_word(req.addr + 32'(8 * i));
          @(posedge clk);
          #1;
          cpl_valid = 1'b0;
          repeat ($urandom_range(2))
          begin
            @(posedge clk);
            #1;
          end
        end
      end
    end
  end

  // --------------------
  // Register port
  // --------------------
  task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge clk);
    #1;
    reg_wr = 1'b0;
  endtask

  // Ack must rise exactly one cycle after the read strobe and last one cycle
  task automatic reg_read(input logic [REG_ADDR_W-1:0] addr, output logic [31:0] data);
    @(posedge clk);
    #1;
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(negedge clk);
    check_val("reg_rd_ack_o", 64'(reg_rd_ack), 64'd0);
    @(posedge clk);
    #1;
    reg_rd = 1'b0;
    @(negedge clk);
    check_val("reg_rd_ack_o", 64'(reg_rd_ack), 64'd1);
    data = reg_rdata;
    @(negedge clk);
    check_val("reg_rd_ack_o", 64'(reg_rd_ack), 64'd0);
  endtask

  task automatic reg_expect(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    reg_read(addr, rd);
    check_val($sformatf("reg_rdata_o @%0d", addr), 64'(rd), 64'(exp));
  endtask

  task automatic setup_stream(input int n, input logic [31:0] src, input int len);
    exp_addr[n]  = src;
    exp_words[n] = len / 8;
    rx_cnt[n]    = 0;
    reg_write(REG_ADDR_W'(REG_SRC_BASE + 2 * n), src);
    reg_write(REG_ADDR_W'(REG_LEN_BASE + 2 * n), 32'(len));
  endtask

  // Polls the control register until every masked enable has cleared
  task automatic wait_streams(input logic [NUM_STRM-1:0] mask);
    logic [31:0] ctrl;
    ctrl = 32'(mask);
    while ((ctrl & 32'(mask)) != 32'd0)
      reg_read(REG_CTRL, ctrl);
  endtask

  task automatic check_req(input int idx, input logic [31:0] addr, input int len, input int tag);
    check_val($sformatf("rd_req_o.addr #%0d", idx), 64'(req_log[idx].addr), 64'(addr));
    check_val($sformatf("rd_req_o.len #%0d", idx), 64'(req_log[idx].len), 64'(len));
    check_val($sformatf("rd_req_o.tag #%0d", idx), 64'(req_log[idx].tag), 64'(tag));
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_reset_state;
    @(negedge clk);
    check_val("rd_req_valid_o", 64'(rd_req_valid), 64'd0);
    check_val("strm_valid_o", 64'(strm_valid), 64'd0);
    check_val("reg_rd_ack_o", 64'(reg_rd_ack), 64'd0);
    reg_expect(REG_CTRL, 32'd0);
    reg_expect(REG_STATUS, 32'd0);
  endtask

  task automatic test_readback;
    for (int n = 0; n < NUM_STRM; n++)
    begin
      reg_write(REG_ADDR_W'(REG_SRC_BASE + 2 * n), 32'hA5C3_0000 + 32'(n * 'h118));
      reg_write(REG_ADDR_W'(REG_LEN_BASE + 2 * n), 32'h0000_0F00 + 32'(n));
    end
    for (int n = 0; n < NUM_STRM; n++)
    begin
      reg_expect(REG_ADDR_W'(REG_SRC_BASE + 2 * n), 32'hA5C3_0000 + 32'(n * 'h118));
      reg_expect(REG_ADDR_W'(REG_LEN_BASE + 2 * n), 32'h0000_0F00 + 32'(n));
    end
    reg_expect(10'd2, 32'd0);
    reg_expect(10'd16, 32'd0);
    reg_expect(10'd1023, 32'd0);
  endtask

  task automatic test_all_streams;
    int lens [NUM_STRM] = '{256, 136, 64, 200};
    for (int n = 0; n < NUM_STRM; n++)
      setup_stream(n, 32'h0010_0000 + 32'(n) * 32'h0001_0000, lens[n]);
    req_log.delete();
    reg_write(REG_CTRL, 32'hF);
    wait_streams(4'hF);
    // Two requests each for 256, 136 and 200 bytes, one for 64
    check_val("request count", 64'(req_log.size()), 64'd7);
    // Round-robin from reset grants stream 0 first
    for (int n = 0; n < NUM_STRM; n++)
      check_val($sformatf("rd_req_o.tag #%0d", n), 64'(req_log[n].tag), 64'(TAG_BASE + n));
    for (int n = 0; n < NUM_STRM; n++)
      check_val($sformatf("word count %0d", n), 64'(rx_cnt[n]), 64'(lens[n] / 8));
    reg_expect(REG_STATUS, 32'hF);
  endtask

  task automatic test_status_clear;
    reg_write(REG_STATUS, 32'b0010);
    reg_expect(REG_STATUS, 32'b1101);
    reg_write(REG_STATUS, 32'b0000);
    reg_expect(REG_STATUS, 32'b1101);
    reg_write(REG_STATUS, 32'b1101);
    reg_expect(REG_STATUS, 32'b0000);
  endtask

  task automatic test_two_requests;
    setup_stream(0, 32'h0040_0000, 256);
    req_log.delete();
    reg_write(REG_CTRL, 32'b0001);
    wait_streams(4'b0001);
    check_val("request count", 64'(req_log.size()), 64'd2);
    check_req(0, 32'h0040_0000, 128, 4);
    check_req(1, 32'h0040_0080, 128, 4);
    check_val("word count 0", 64'(rx_cnt[0]), 64'd32);
    reg_expect(REG_STATUS, 32'b0001);
    reg_expect(REG_CTRL, 32'd0);
  endtask

  task automatic test_backpressure;
    rand_ack[2] = 1'b1;
    setup_stream(2, 32'h0080_0008, 200);
    req_log.delete();
    reg_write(REG_CTRL, 32'b0100);
    wait_streams(4'b0100);
    rand_ack[2] = 1'b0;
    check_val("request count", 64'(req_log.size()), 64'd2);
    check_req(0, 32'h0080_0008, 128, 6);
    check_req(1, 32'h0080_0088, 72, 6);
    check_val("word count 2", 64'(rx_cnt[2]), 64'd25);
    reg_expect(REG_STATUS, 32'b0101);
    reg_expect(REG_CTRL, 32'd0);
  endtask

  initial
  begin
    void'($urandom(58693));
    rst        = 1'b1;
    reg_wr     = 1'b0;
    reg_rd     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    rd_req_ack = 1'b0;
    cpl_valid  = 1'b0;
    cpl_tag    = '0;
    cpl_data   = '0;
    strm_ack   = '0;
    rand_ack   = '0;
    for (int n = 0; n < NUM_STRM; n++)
    begin
      exp_addr[n]  = '0;
      exp_words[n] = 0;
      rx_cnt[n]    = 0;
    end
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    test_reset_state();
    test_readback();
    test_all_streams();
    test_status_clear();
    test_two_requests();
    test_backpressure();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
logic/pcie_app_pkg.sv
logic/pcie_reg_file.sv
logic/user_pcie_stream_gen.sv
logic/user_dma_req_arbiter.sv
logic/pcie_app.sv
verification/pcie_app_tb.sv

// ==== Makefile ====
SIM  := obj_dir/Vpcie_app_tb
SRCS := $(shell cat vlog.f)

.PHONY: run clean

run: $(SIM)
	./$(SIM)

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module pcie_app_tb -f vlog.f

clean:
	rm -rf obj_dir
